// File: verilog/keccak_io_settings.svh
/*
 * keccak_io settings
 * lane width, rate block size, length width and the rate of every
 * supported function for the sponge I/O buffer
 */
`ifndef KECCAK_IO_SETTINGS_SVH
`define KECCAK_IO_SETTINGS_SVH

// one bus lane, also the keccak lane size
`define KIO_LANE_WIDTH 64

// widest rate block, shake128
`define KIO_MAX_RATE 1344
`define KIO_MAX_LANES 21

// message length counter, in lanes
`define KIO_LEN_WIDTH 16

// rate in bits per function
`define KIO_RATE_SHAKE128 1344
`define KIO_RATE_SHAKE256 1088
`define KIO_RATE_SHA3_256 1088
`define KIO_RATE_SHA3_512 576

`endif

// File: verilog/keccak_io_pkg.sv
/*
 * keccak_io package
 * types shared by the sponge I/O buffer blocks and the rate lookup
 */
`include "keccak_io_settings.svh"

package keccak_io_pkg;

    // function select encoding
    typedef enum logic [1:0] {
        shake128 = 2'd0,
        shake256 = 2'd1,
        sha3_256 = 2'd2,
        sha3_512 = 2'd3
    } keccak_fn_e;

    // buffer mode, code 3 behaves as hold too
    typedef enum logic [1:0] {
        absorb  = 2'd0,
        squeeze = 2'd1,
        hold    = 2'd2
    } io_mode_e;

    typedef logic [`KIO_LANE_WIDTH-1:0] lane_t;
    typedef logic [`KIO_LEN_WIDTH-1:0]  lane_count_t;

    // rate block, filled by lanes and read as a flat bit vector
    // lane 0 sits in the low bits
    typedef union packed {
        logic [`KIO_MAX_RATE-1:0]      bits;
        lane_t [`KIO_MAX_LANES-1:0]    lanes;
    } rate_block_u;

    // lanes per rate block for a given function
    function automatic lane_count_t rate_lanes(keccak_fn_e fn);
        lane_count_t lanes;
        case (fn)
            shake128: lanes = lane_count_t'(`KIO_RATE_SHAKE128 / `KIO_LANE_WIDTH);
            shake256: lanes = lane_count_t'(`KIO_RATE_SHAKE256 / `KIO_LANE_WIDTH);
            sha3_256: lanes = lane_count_t'(`KIO_RATE_SHA3_256 / `KIO_LANE_WIDTH);
            default:  lanes = lane_count_t'(`KIO_RATE_SHA3_512 / `KIO_LANE_WIDTH);
        endcase
        return lanes;
    endfunction

endpackage

// File: verilog/absorb_packer.sv
/*
 * absorb packer
 * collects message lanes into a rate block, counts lanes per block and
 * per message, and presents full data blocks, the padded final block and
 * an extra padding-only block when the message ends on a rate boundary
 */
`include "keccak_io_settings.svh"

module absorb_packer (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic                       start,
    input  keccak_io_pkg::io_mode_e    mode,
    input  keccak_io_pkg::keccak_fn_e  function_sel,
    input  keccak_io_pkg::lane_count_t inlen,
    input  keccak_io_pkg::lane_t       din,
    input  logic                       din_valid,
    input  logic                       perm_ready,
    input  keccak_io_pkg::rate_block_u padded_block,
    output logic                       din_ready,
    output keccak_io_pkg::rate_block_u raw_block,
    output keccak_io_pkg::lane_count_t fill_lanes,
    output keccak_io_pkg::rate_block_u absorb_block,
    output logic                       absorb_block_valid,
    output logic                       absorb_block_last
);

    localparam int LANE_IDX_W = $clog2(`KIO_MAX_LANES);

    keccak_io_pkg::rate_block_u block_q;
    keccak_io_pkg::lane_count_t fill_q;
    keccak_io_pkg::lane_count_t sent_q;
    logic                       valid_q;
    logic                       last_q;
    logic                       done_q;

    logic                       is_absorb;
    logic                       msg_done;
    logic                       lane_take;
    logic                       block_full_next;
    logic                       msg_end_next;
    logic [LANE_IDX_W-1:0]      fill_idx;

    //////////////////////////////////////////////////////////////////////
    // lane acceptance
    //////////////////////////////////////////////////////////////////////
    assign is_absorb = (mode == keccak_io_pkg::absorb);
    assign msg_done  = (sent_q == inlen);
    // no lane taken while a block waits or after the final one
    assign din_ready = is_absorb && !valid_q && !done_q && !msg_done;
    assign lane_take = din_valid && din_ready;
    assign fill_idx  = fill_q[LANE_IDX_W-1:0];

    // this lane closes the block or the message
    assign block_full_next =
        ((fill_q + 1'b1) == keccak_io_pkg::rate_lanes(function_sel));
    assign msg_end_next = ((sent_q + 1'b1) == inlen);

    //////////////////////////////////////////////////////////////////////
    // block register and flags
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            block_q <= '0;
            fill_q  <= '0;
            sent_q  <= '0;
            valid_q <= 1'b0;
            last_q  <= 1'b0;
            done_q  <= 1'b0;
        end else if (start) begin
            block_q <= '0;
            fill_q  <= '0;
            sent_q  <= '0;
            valid_q <= 1'b0;
            last_q  <= 1'b0;
            done_q  <= 1'b0;
        end else if (is_absorb) begin
            if (valid_q) begin
                // core takes the block on this edge
                if (perm_ready) begin
                    block_q <= '0;
                    fill_q  <= '0;
                    valid_q <= 1'b0;
                    last_q  <= 1'b0;
                    if (last_q) begin
                        done_q <= 1'b1;
                    end else if (msg_done) begin
                        // message ended on a rate boundary, padding only
                        valid_q <= 1'b1;
                        last_q  <= 1'b1;
                    end
                end
            end else if (msg_done && !done_q) begin
                // empty message gets a padding-only block
                valid_q <= 1'b1;
                last_q  <= 1'b1;
            end else if (lane_take) begin
                block_q.lanes[fill_idx] <= din;
                fill_q <= fill_q + 1'b1;
                sent_q <= sent_q + 1'b1;
                if (block_full_next || msg_end_next) begin
                    valid_q <= 1'b1;
                    // full block is never the padded one
                    last_q  <= !block_full_next;
                end
            end
        end
    end

    // padder sees the raw block and its fill level
    assign raw_block  = block_q;
    assign fill_lanes = fill_q;

    assign absorb_block       = last_q ? padded_block : block_q;
    assign absorb_block_valid = valid_q;
    assign absorb_block_last  = last_q;

endmodule

// File: verilog/sponge_padder.sv
/*
 * sponge padder
 * keeps the filled lanes of the final block, clears the rest, writes the
 * SHAKE or SHA3 domain suffix after the last lane and sets the closing
 * pad bit at the top of the rate
 */
`include "keccak_io_settings.svh"

module sponge_padder (
    input  keccak_io_pkg::keccak_fn_e  function_sel,
    input  keccak_io_pkg::rate_block_u raw_block,
    input  keccak_io_pkg::lane_count_t fill_lanes,
    output keccak_io_pkg::rate_block_u padded_block
);

    localparam int BIT_IDX_W = $clog2(`KIO_MAX_RATE);

    logic [BIT_IDX_W-1:0] pad_pos;
    logic [BIT_IDX_W-1:0] end_pos;
    logic                 is_shake;

    // suffix starts right after the last message lane
    assign pad_pos = BIT_IDX_W'(fill_lanes * `KIO_LANE_WIDTH);
    // top bit of the rate
    assign end_pos =
        BIT_IDX_W'(keccak_io_pkg::rate_lanes(function_sel) * `KIO_LANE_WIDTH - 1);

    assign is_shake = (function_sel == keccak_io_pkg::shake128) ||
                      (function_sel == keccak_io_pkg::shake256);

    //////////////////////////////////////////////////////////////////////
    // pad10*1 with domain suffix
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        padded_block.bits = '0;

        // message lanes pass, everything above is zero
        for (int i = 0; i < `KIO_MAX_LANES; i++) begin
            if (i < fill_lanes) begin
                padded_block.lanes[i] = raw_block.lanes[i];
            end
        end

        // shake suffix 1111 plus first pad bit
        if (is_shake) begin
            padded_block.bits[pad_pos +: 5] = 5'b11111;
        end else begin
            // sha3 suffix 01 plus first pad bit, low to high
            padded_block.bits[pad_pos +: 3] = 3'b110;
        end

        // closing bit of the pad
        padded_block.bits[end_pos] = 1'b1;
    end

endmodule

// File: verilog/squeeze_unloader.sv
/*
 * squeeze unloader
 * captures a permutation result and sends it out one lane per cycle,
 * lane 0 first; a new capture on the last lane keeps the stream gapless
 */
`include "keccak_io_settings.svh"

module squeeze_unloader (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic                       start,
    input  keccak_io_pkg::io_mode_e    mode,
    input  keccak_io_pkg::keccak_fn_e  function_sel,
    input  logic                       perm_ready,
    input  keccak_io_pkg::rate_block_u squeeze_block,
    output keccak_io_pkg::lane_t       dout,
    output logic                       dout_valid
);

    keccak_io_pkg::rate_block_u shift_q;
    keccak_io_pkg::lane_count_t left_q;

    logic is_squeeze;
    logic sending;
    logic capture;

    assign is_squeeze = (mode == keccak_io_pkg::squeeze);
    assign sending    = (left_q != '0);

    // idle or on the last lane, so a new result may enter
    assign capture = is_squeeze && perm_ready && (left_q <= 1);

    //////////////////////////////////////////////////////////////////////
    // lanes left counter
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            left_q <= '0;
        end else if (start) begin
            left_q <= '0;
        end else begin
            case (mode)
                keccak_io_pkg::squeeze: begin
                    if (capture) begin
                        left_q <= keccak_io_pkg::rate_lanes(function_sel);
                    end else if (sending) begin
                        left_q <= left_q - 1'b1;
                    end
                end
                // absorb and hold keep the stream frozen
                default: begin
                    left_q <= left_q;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // lane shift register
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (capture) begin
            shift_q <= squeeze_block;
        end else if (is_squeeze && sending) begin
            // next lane moves down into lane 0
            shift_q.bits <= shift_q.bits >> `KIO_LANE_WIDTH;
        end
    end

    assign dout = shift_q.lanes[0];

    // only valid while squeezing, hold forces it low
    assign dout_valid = is_squeeze && sending;

endmodule

// File: verilog/keccak_io.sv
/*
 * keccak_io
 * sponge I/O buffer between a 64-bit lane bus and a Keccak-p[1600,24]
 * core. Packs message lanes into padded rate blocks for absorption and
 * unloads permutation results one lane per cycle when squeezing.
 */
module keccak_io (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic                       start,
    input  keccak_io_pkg::io_mode_e    mode,
    input  keccak_io_pkg::keccak_fn_e  function_sel,
    input  keccak_io_pkg::lane_count_t inlen,
    input  keccak_io_pkg::lane_t       din,
    input  logic                       din_valid,
    input  logic                       perm_ready,
    input  keccak_io_pkg::rate_block_u squeeze_block,
    output logic                       din_ready,
    output keccak_io_pkg::rate_block_u absorb_block,
    output logic                       absorb_block_valid,
    output logic                       absorb_block_last,
    output keccak_io_pkg::lane_t       dout,
    output logic                       dout_valid
);

    // packer to padder and back
    keccak_io_pkg::rate_block_u raw_block;
    keccak_io_pkg::rate_block_u padded_block;
    keccak_io_pkg::lane_count_t fill_lanes;

    //////////////////////////////////////////////////////////////////////
    // absorb path
    //////////////////////////////////////////////////////////////////////
    absorb_packer packer_i (
        .clk_i              (clk_i),
        .rst_ni             (rst_ni),
        .start              (start),
        .mode               (mode),
        .function_sel       (function_sel),
        .inlen              (inlen),
        .din                (din),
        .din_valid          (din_valid),
        .perm_ready         (perm_ready),
        .padded_block       (padded_block),
        .din_ready          (din_ready),
        .raw_block          (raw_block),
        .fill_lanes         (fill_lanes),
        .absorb_block       (absorb_block),
        .absorb_block_valid (absorb_block_valid),
        .absorb_block_last  (absorb_block_last)
    );

    sponge_padder padder_i (
        .function_sel (function_sel),
        .raw_block    (raw_block),
        .fill_lanes   (fill_lanes),
        .padded_block (padded_block)
    );

    //////////////////////////////////////////////////////////////////////
    // squeeze path
    //////////////////////////////////////////////////////////////////////
    squeeze_unloader unloader_i (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .start         (start),
        .mode          (mode),
        .function_sel  (function_sel),
        .perm_ready    (perm_ready),
        .squeeze_block (squeeze_block),
        .dout          (dout),
        .dout_valid    (dout_valid)
    );

endmodule

// File: test/tb_keccak_io.sv
/*
 * keccak_io testbench
 * absorbs messages for several functions, with and without core stalls,
 * squeezes one result, cuts a stream and a stalled block short with start
 * and checks blocks and lanes against a local model
 */
`include "keccak_io_settings.svh"

module tb_keccak_io;

    localparam int TIMEOUT_CYCLES = 500;

    logic                       clk_i;
    logic                       rst_ni;
    logic                       start;
    keccak_io_pkg::io_mode_e    mode;
    keccak_io_pkg::keccak_fn_e  function_sel;
    keccak_io_pkg::lane_count_t inlen;
    keccak_io_pkg::lane_t       din;
    logic                       din_valid;
    logic                       perm_ready;
    keccak_io_pkg::rate_block_u squeeze_block;
    logic                       din_ready;
    keccak_io_pkg::rate_block_u absorb_block;
    logic                       absorb_block_valid;
    logic                       absorb_block_last;
    keccak_io_pkg::lane_t       dout;
    logic                       dout_valid;

    integer seed;
    int     error_count;

    // filled by stimulus, drained by the compare process
    keccak_io_pkg::rate_block_u exp_blocks[$];
    logic                       exp_last[$];
    keccak_io_pkg::lane_t       exp_lanes[$];
    keccak_io_pkg::lane_t       msg[$];

    // block seen while the core stalls
    logic                       held;
    keccak_io_pkg::rate_block_u held_block;

    keccak_io dut_i (.*);

    initial clk_i = 1'b0;
    always #10 clk_i = ~clk_i;

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////
    // lanes in the rate of each function
    function automatic int lanes_in_rate(input keccak_io_pkg::keccak_fn_e fn);
        case (fn)
            keccak_io_pkg::shake128: return 21;
            keccak_io_pkg::shake256: return 17;
            keccak_io_pkg::sha3_256: return 17;
            default:                 return 9;
        endcase
    endfunction

    // final block from the lanes left over after the last full block
    function automatic keccak_io_pkg::rate_block_u pad_ref(
        input keccak_io_pkg::rate_block_u raw,
        input keccak_io_pkg::keccak_fn_e  fn,
        input int                         fill
    );
        keccak_io_pkg::rate_block_u res;
        int                         base;
        res  = '0;
        base = fill * `KIO_LANE_WIDTH;
        for (int i = 0; i < fill; i++) begin
            res.lanes[i] = raw.lanes[i];
        end
        if (fn == keccak_io_pkg::shake128 || fn == keccak_io_pkg::shake256) begin
            for (int j = 0; j < 5; j++) begin
                res.bits[base + j] = 1'b1;
            end
        end else begin
            // suffix 0,1 then the first pad bit
            res.bits[base + 1] = 1'b1;
            res.bits[base + 2] = 1'b1;
        end
        res.bits[lanes_in_rate(fn) * `KIO_LANE_WIDTH - 1] = 1'b1;
        return res;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////////////////////////
    task automatic check_block(input string name, input keccak_io_pkg::rate_block_u got,
                               input keccak_io_pkg::rate_block_u exp);
        if (got !== exp) begin
            error_count++;
            $display("Error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_lane(input string name, input keccak_io_pkg::lane_t got,
                              input keccak_io_pkg::lane_t exp);
        if (got !== exp) begin
            error_count++;
            $display("Error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            error_count++;
            $display("Error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_idle();
        @(negedge clk_i);
        check_flag("din_ready", din_ready, 1'b0);
        check_flag("absorb_block_valid", absorb_block_valid, 1'b0);
        check_flag("absorb_block_last", absorb_block_last, 1'b0);
        check_flag("dout_valid", dout_valid, 1'b0);
    endtask

    task automatic abort_on_timeout(input string what);
        $display("Timed out waiting for %s", what);
        $display("errors: %0d", error_count + 1);
        $display("Test failures found");
        $finish;
    endtask

    //////////////////////////////////////////////////////////////////////
    // compare process on the falling edge
    //////////////////////////////////////////////////////////////////////
    always @(negedge clk_i) begin
        if (absorb_block_valid) begin
            check_flag("din_ready", din_ready, 1'b0);
            // stalled block must not move
            if (held) begin
                check_block("absorb_block", absorb_block, held_block);
            end
            if (perm_ready) begin
                held = 1'b0;
                if (exp_blocks.size() == 0) begin
                    error_count++;
                    $display("a block was presented when none was expected");
                end else begin
                    check_block("absorb_block", absorb_block, exp_blocks.pop_front());
                    check_flag("absorb_block_last", absorb_block_last, exp_last.pop_front());
                end
            end else begin
                held       = 1'b1;
                held_block = absorb_block;
            end
        end else begin
            held = 1'b0;
        end
        if (dout_valid) begin
            if (exp_lanes.size() == 0) begin
                error_count++;
                $display("a lane appeared on dout when none was expected");
            end else begin
                check_lane("dout", dout, exp_lanes.pop_front());
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////
    task automatic absorb_msg(input keccak_io_pkg::keccak_fn_e fn, input int n,
                              input int max_stall);
        keccak_io_pkg::rate_block_u blk;
        int                         fill;
        int                         nblk;
        int                         wait_in;
        int                         wait_acc;
        int                         stall;
        blk  = '0;
        fill = 0;
        nblk = n / lanes_in_rate(fn) + 1;
        msg.delete();
        // full blocks first, then the padded one
        for (int i = 0; i < n; i++) begin
            msg.push_back({$random(seed), $random(seed)});
            blk.lanes[fill] = msg[i];
            fill++;
            if (fill == lanes_in_rate(fn)) begin
                exp_blocks.push_back(blk);
                exp_last.push_back(1'b0);
                blk  = '0;
                fill = 0;
            end
        end
        exp_blocks.push_back(pad_ref(blk, fn, fill));
        exp_last.push_back(1'b1);

        @(posedge clk_i);
        start        <= 1'b1;
        mode         <= keccak_io_pkg::absorb;
        function_sel <= fn;
        inlen        <= keccak_io_pkg::lane_count_t'(n);
        perm_ready   <= (max_stall == 0);
        din_valid    <= 1'b0;
        @(posedge clk_i);
        start <= 1'b0;
        fork
            begin
                // lane feeder
                for (int i = 0; i < n; i++) begin
                    din       <= msg[i];
                    din_valid <= 1'b1;
                    wait_in   = 0;
                    @(negedge clk_i);
                    while (!din_ready) begin
                        wait_in++;
                        if (wait_in > TIMEOUT_CYCLES) abort_on_timeout("din_ready");
                        @(negedge clk_i);
                    end
                    @(posedge clk_i);
                end
                din_valid <= 1'b0;
            end
            begin
                // core acceptor with a random stall per block
                for (int b = 0; b < nblk && max_stall > 0; b++) begin
                    wait_acc = 0;
                    @(negedge clk_i);
                    while (!absorb_block_valid) begin
                        wait_acc++;
                        if (wait_acc > TIMEOUT_CYCLES) abort_on_timeout("absorb_block_valid");
                        @(negedge clk_i);
                    end
                    stall = 1 + ($unsigned($random(seed)) % max_stall);
                    repeat (stall) @(posedge clk_i);
                    perm_ready <= 1'b1;
                    @(posedge clk_i);
                    perm_ready <= 1'b0;
                end
            end
        join
        wait_in = 0;
        while (exp_blocks.size() != 0) begin
            @(posedge clk_i);
            wait_in++;
            if (wait_in > TIMEOUT_CYCLES) abort_on_timeout("the last absorb block");
        end
        perm_ready <= 1'b0;
    endtask

    task automatic squeeze_run(input keccak_io_pkg::keccak_fn_e fn);
        keccak_io_pkg::rate_block_u blk;
        for (int k = 0; k < `KIO_MAX_LANES; k++) begin
            blk.lanes[k] = {$random(seed), $random(seed)};
        end
        for (int k = 0; k < lanes_in_rate(fn); k++) begin
            exp_lanes.push_back(blk.bits[k * `KIO_LANE_WIDTH +: `KIO_LANE_WIDTH]);
        end
        @(posedge clk_i);
        mode          <= keccak_io_pkg::squeeze;
        function_sel  <= fn;
        squeeze_block <= blk;
        perm_ready    <= 1'b1;
        // captured on this edge
        @(posedge clk_i);
        perm_ready <= 1'b0;
        for (int k = 0; k < lanes_in_rate(fn); k++) begin
            @(negedge clk_i);
            if (!dout_valid) begin
                error_count++;
                $display("squeeze lane %0d did not appear on time", k);
            end
        end
        @(negedge clk_i);
        if (dout_valid || exp_lanes.size() != 0) begin
            error_count++;
            $display("squeeze stream did not end after the last rate lane");
        end
    endtask

    // start pulse in the middle of a squeeze stream and of a stalled block
    task automatic interrupt_with_start();
        keccak_io_pkg::rate_block_u blk;
        int                         wait_blk;
        for (int k = 0; k < `KIO_MAX_LANES; k++) begin
            blk.lanes[k] = {$random(seed), $random(seed)};
        end
        // three lanes leave before start cuts the stream
        for (int k = 0; k < 3; k++) begin
            exp_lanes.push_back(blk.bits[k * `KIO_LANE_WIDTH +: `KIO_LANE_WIDTH]);
        end
        @(posedge clk_i);
        mode          <= keccak_io_pkg::squeeze;
        function_sel  <= keccak_io_pkg::sha3_256;
        squeeze_block <= blk;
        perm_ready    <= 1'b1;
        @(posedge clk_i);
        perm_ready <= 1'b0;
        repeat (2) @(posedge clk_i);
        start <= 1'b1;
        @(posedge clk_i);
        start <= 1'b0;
        check_idle();

        // two lane message, the core never takes its final block
        @(posedge clk_i);
        mode      <= keccak_io_pkg::absorb;
        inlen     <= keccak_io_pkg::lane_count_t'(2);
        din       <= blk.lanes[0];
        din_valid <= 1'b1;
        wait_blk  = 0;
        @(negedge clk_i);
        while (!absorb_block_valid) begin
            wait_blk++;
            if (wait_blk > TIMEOUT_CYCLES) abort_on_timeout("the stalled absorb block");
            @(negedge clk_i);
        end
        @(posedge clk_i);
        din_valid <= 1'b0;
        mode      <= keccak_io_pkg::hold;
        start     <= 1'b1;
        @(posedge clk_i);
        start <= 1'b0;
        check_idle();
    endtask

    initial begin
        seed          = 32'h7e7617b2;
        error_count   = 0;
        held          = 1'b0;
        held_block    = '0;
        rst_ni        = 1'b0;
        start         = 1'b0;
        // squeeze leaves dout_valid to the lane counter reset
        mode          = keccak_io_pkg::squeeze;
        function_sel  = keccak_io_pkg::shake128;
        inlen         = '0;
        din           = '0;
        din_valid     = 1'b0;
        perm_ready    = 1'b0;
        squeeze_block = '0;
        repeat (4) @(posedge clk_i);
        rst_ni <= 1'b1;
        check_idle();

        absorb_msg(keccak_io_pkg::shake128, 30, 0);
        absorb_msg(keccak_io_pkg::sha3_512, 4, 0);
        // ends on a rate boundary so a padding-only block follows
        absorb_msg(keccak_io_pkg::sha3_512, 9, 0);
        absorb_msg(keccak_io_pkg::shake256, 40, 6);
        squeeze_run(keccak_io_pkg::sha3_256);
        interrupt_with_start();

        $display("errors: %0d", error_count);
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: keccak_io.f
+incdir+verilog
verilog/keccak_io_pkg.sv
verilog/absorb_packer.sv
verilog/sponge_padder.sv
verilog/squeeze_unloader.sv
verilog/keccak_io.sv
test/tb_keccak_io.sv
